//--- Bender.yml
package:
  name: exu_ecl

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_ecl_pkg.sv
      - verilog/exu_ecl_bypass.sv
      - verilog/exu_ecl_dispatch.sv
      - verilog/exu_ecl_writeback.sv
      - verilog/exu_ecl_lsu_stall.sv
      - verilog/exu_ecl.sv
  - target: test
    include_dirs:
      - verilog
      - dv
    files:
      - dv/exu_ecl_tb.sv

//--- dv/exu_ecl_tests.svh
`ifndef EXU_ECL_TESTS_SVH
`define EXU_ECL_TESTS_SVH

task reset_values;
   begin
      test_name = "reset";
      repeat (2) begin
         check_bit("lsu_valid_e", 1'b0, lsu_valid_e);
         check_bit("bru_valid_e", 1'b0, bru_valid_e);
         check_bit("br_taken_e", 1'b0, br_taken_e);
         check_bit("rd_wen_w", 1'b0, rd_wen_w);
         check_bit("stall_req", 1'b0, stall_req);
         step();
      end
   end
endtask

// one alu instruction from decode to writeback
task alu_case(input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk,
              input logic rd2rj, input logic rd_read, input logic pc_rel, input logic use_imm);
   word_t   exp_a;
   word_t   exp_b;
   word_t   exp_c;
   word_t   res;
   alu_op_t exp_op;
   logic    exp_dw;
   begin
      drive_alu(rd, rj, rk, rd2rj, rd_read, pc_rel, use_imm);
      #1;
      check_addr("rs1_addr_d", rd2rj ? rd : rj, rs1_addr_d);
      check_addr("rs2_addr_d", rd_read ? rd : rk, rs2_addr_d);
      exp_a  = pc_rel ? pc_d : rs1_data_d;
      exp_b  = use_imm ? imm_d : rs2_data_d;
      exp_c  = c_d;
      exp_op = op_d.alu_op;
      exp_dw = op_d.double_word;
      step();
      check_word("alu_a_e", exp_a, alu_a_e);
      check_word("alu_b_e", exp_b, alu_b_e);
      check_word("alu_c_e", exp_c, alu_c_e);
      check_word("alu_op_e", word_t'(exp_op), word_t'(alu_op_e));
      check_bit("alu_double_word_e", exp_dw, alu_double_word_e);
      res       = rand_word();
      alu_res_e = res;
      go_idle();
      step();
      check_bit("rd_wen_w early", 1'b0, rd_wen_w);
      step();
      check_bit("rd_wen_w", 1'b1, rd_wen_w);
      check_addr("rd_addr_w", rd, rd_addr_w);
      check_word("rd_data_w", res, rd_data_w);
   end
endtask

task alu_operand_select;
   begin
      test_name = "alu_operands";
      alu_case(5'd5, 5'd6, 5'd7, 1'b0, 1'b0, 1'b1, 1'b1);
      alu_case(5'd9, 5'd10, 5'd11, 1'b1, 1'b1, 1'b0, 1'b0);
      alu_case(5'd17, 5'd18, 5'd19, 1'b0, 1'b1, 1'b1, 1'b0);
      alu_case(5'd20, 5'd21, 5'd22, 1'b1, 1'b0, 1'b0, 1'b1);
      drain();
   end
endtask

task forwarding_paths;
   word_t res_a;
   word_t res_b;
   word_t exp_a;
   word_t exp_b;
   begin
      test_name = "forwarding";
      // back to back, rs1 from the memory stage
      drive_alu(5'd3, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      res_a     = rand_word();
      alu_res_e = res_a;
      drive_alu(5'd8, 5'd3, 5'd4, 1'b0, 1'b0, 1'b0, 1'b0);
      exp_b = rs2_data_d;
      step();
      check_word("alu_a_e from memory", res_a, alu_a_e);
      check_word("alu_b_e from register", exp_b, alu_b_e);
      drain();
      // one bubble apart, rs2 from the writeback stage
      drive_alu(5'd13, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      res_b     = rand_word();
      alu_res_e = res_b;
      go_idle();
      step();
      drive_alu(5'd9, 5'd14, 5'd13, 1'b0, 1'b0, 1'b0, 1'b0);
      exp_a = rs1_data_d;
      step();
      check_word("alu_a_e from register", exp_a, alu_a_e);
      check_word("alu_b_e from writeback", res_b, alu_b_e);
      drain();
      // memory stage beats writeback for the same register
      drive_alu(5'd15, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      alu_res_e = rand_word();
      drive_alu(5'd15, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      res_a     = rand_word();
      alu_res_e = res_a;
      drive_alu(5'd10, 5'd15, 5'd15, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      check_word("alu_a_e memory priority", res_a, alu_a_e);
      check_word("alu_b_e memory priority", res_a, alu_b_e);
      drain();
      // r0 is never forwarded
      drive_alu(5'd0, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      alu_res_e = rand_word();
      drive_alu(5'd11, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
      exp_a = rs1_data_d;
      exp_b = rs2_data_d;
      step();
      check_word("alu_a_e for r0", exp_a, alu_a_e);
      check_word("alu_b_e for r0", exp_b, alu_b_e);
      drain();
      // immediate b stays the immediate
      drive_alu(5'd16, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      res_a     = rand_word();
      alu_res_e = res_a;
      drive_alu(5'd12, 5'd16, 5'd16, 1'b0, 1'b0, 1'b0, 1'b1);
      exp_b = imm_d;
      step();
      check_word("alu_a_e forwarded", res_a, alu_a_e);
      check_word("alu_b_e immediate", exp_b, alu_b_e);
      drain();
   end
endtask

// wait a random time with stall_req held, then return load data
task return_load(input reg_addr_t rd);
   word_t       load_data;
   int unsigned delay;
   begin
      go_idle();
      delay = 1 + ($urandom % 4);
      repeat (delay) begin
         step();
         check_bit("stall_req while waiting", 1'b1, stall_req);
      end
      load_data         = rand_word();
      lsu_rdata_m       = load_data;
      lsu_rd_m          = rd;
      lsu_wen_m         = 1'b1;
      lsu_rdata_valid_m = 1'b1;
      #1;
      check_bit("stall_req on return", 1'b0, stall_req);
      step();
      check_bit("stall_req after return", 1'b0, stall_req);
      check_bit("rd_wen_w load", 1'b1, rd_wen_w);
      check_addr("rd_addr_w load", rd, rd_addr_w);
      check_word("rd_data_w load", load_data, rd_data_w);
      lsu_rdata_valid_m = 1'b0;
      lsu_wen_m         = 1'b0;
   end
endtask

task load_stall_path;
   word_t   exp_base;
   word_t   exp_offs;
   word_t   fwd_val;
   lsu_op_t exp_op;
   begin
      test_name = "load_path";
      // immediate offset
      drive_lsu(5'd22, 5'd20, 5'd21, 1'b0);
      #1;
      check_bit("stall_req in dispatch", 1'b1, stall_req);
      exp_base = rs1_data_d;
      exp_offs = imm_d;
      exp_op   = op_d.lsu_op;
      step();
      check_bit("lsu_valid_e", 1'b1, lsu_valid_e);
      check_word("lsu_op_e", word_t'(exp_op), word_t'(lsu_op_e));
      check_word("lsu_base_e", exp_base, lsu_base_e);
      check_word("lsu_offset_e imm", exp_offs, lsu_offset_e);
      check_addr("lsu_rd_e", 5'd22, lsu_rd_e);
      check_bit("lsu_wen_e", 1'b1, lsu_wen_e);
      check_bit("stall_req in execute", 1'b1, stall_req);
      return_load(5'd22);
      drain();
      // base forwarded from the alu just ahead but never the indexed offset
      drive_alu(5'd23, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      step();
      fwd_val   = rand_word();
      alu_res_e = fwd_val;
      drive_lsu(5'd24, 5'd23, 5'd23, 1'b1);
      exp_offs = rs2_data_d;
      step();
      check_bit("lsu_valid_e indexed", 1'b1, lsu_valid_e);
      check_word("lsu_base_e forwarded", fwd_val, lsu_base_e);
      check_word("lsu_offset_e register", exp_offs, lsu_offset_e);
      check_word("lsu_wdata_e register", exp_offs, lsu_wdata_e);
      return_load(5'd24);
      drain();
   end
endtask

task branch_kill;
   word_t   exp_a;
   word_t   exp_b;
   word_t   exp_pc;
   word_t   exp_offs;
   word_t   link_pc;
   word_t   target_pc;
   bru_op_t exp_op;
   begin
      test_name = "branch";
      drive_bru(5'd1, 5'd26, 5'd27);
      exp_a    = rs1_data_d;
      exp_b    = rs2_data_d;
      exp_pc   = pc_d;
      exp_offs = br_offs_d;
      exp_op   = op_d.bru_op;
      step();
      check_bit("bru_valid_e", 1'b1, bru_valid_e);
      check_word("bru_a_e", exp_a, bru_a_e);
      check_word("bru_b_e", exp_b, bru_b_e);
      check_word("bru_pc_e", exp_pc, bru_pc_e);
      check_word("bru_offset_e", exp_offs, bru_offset_e);
      check_word("bru_op_e", word_t'(exp_op), word_t'(bru_op_e));
      check_bit("br_taken_e not taken", 1'b0, br_taken_e);
      // taken with link, the alu in decode is squashed
      link_pc       = rand_word();
      target_pc     = rand_word();
      bru_taken_e   = 1'b1;
      bru_wen_e     = 1'b1;
      bru_link_pc_e = link_pc;
      bru_brpc_e    = target_pc;
      drive_alu(5'd28, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, 1'b0);
      #1;
      check_bit("br_taken_e", 1'b1, br_taken_e);
      check_word("br_pc_e", target_pc, br_pc_e);
      step();
      check_bit("bru_valid_e after kill", 1'b0, bru_valid_e);
      check_bit("lsu_valid_e after kill", 1'b0, lsu_valid_e);
      check_bit("br_taken_e after kill", 1'b0, br_taken_e);
      bru_taken_e = 1'b0;
      bru_wen_e   = 1'b0;
      alu_res_e   = rand_word();
      go_idle();
      step();
      check_bit("rd_wen_w link", 1'b1, rd_wen_w);
      check_addr("rd_addr_w link", 5'd1, rd_addr_w);
      check_word("rd_data_w link", link_pc, rd_data_w);
      step();
      check_bit("rd_wen_w squashed alu", 1'b0, rd_wen_w);
      drain();
      // squashed load raises no stall
      drive_bru(5'd2, 5'd26, 5'd27);
      step();
      bru_taken_e = 1'b1;
      drive_lsu(5'd29, 5'd20, 5'd21, 1'b0);
      #1;
      check_bit("stall_req squashed load", 1'b0, stall_req);
      step();
      check_bit("lsu_valid_e squashed load", 1'b0, lsu_valid_e);
      go_idle();
      #1;
      check_bit("stall_req after squash", 1'b0, stall_req);
      bru_taken_e = 1'b0;
      drain();
   end
endtask

`endif

//--- dv/exu_ecl_tb.sv
`default_nettype none

`include "exu_ecl_config.svh"

module exu_ecl_tb;
   import exu_ecl_pkg::*;

   localparam int clk_period      = 20;
   localparam int num_tests       = 5;
   localparam int cycles_per_test = 200;

   // DUT inputs
   logic        clk;
   logic        rst_n;
   logic        valid_d;
   logic [31:0] inst_d;
   word_t       pc_d;
   decoded_op_t op_d;
   logic        rf_wen_d;
   reg_addr_t   rf_target_d;
   word_t       imm_d;
   word_t       c_d;
   word_t       br_offs_d;
   word_t       rs1_data_d;
   word_t       rs2_data_d;
   word_t       alu_res_e;
   word_t       lsu_rdata_m;
   logic        lsu_rdata_valid_m;
   reg_addr_t   lsu_rd_m;
   logic        lsu_wen_m;
   word_t       bru_brpc_e;
   logic        bru_taken_e;
   word_t       bru_link_pc_e;
   logic        bru_wen_e;

   // DUT outputs
   reg_addr_t   rs1_addr_d;
   reg_addr_t   rs2_addr_d;
   word_t       alu_a_e;
   word_t       alu_b_e;
   alu_op_t     alu_op_e;
   word_t       alu_c_e;
   logic        alu_double_word_e;
   logic        lsu_valid_e;
   lsu_op_t     lsu_op_e;
   word_t       lsu_base_e;
   word_t       lsu_offset_e;
   word_t       lsu_wdata_e;
   reg_addr_t   lsu_rd_e;
   logic        lsu_wen_e;
   logic        bru_valid_e;
   bru_op_t     bru_op_e;
   word_t       bru_a_e;
   word_t       bru_b_e;
   word_t       bru_pc_e;
   word_t       bru_offset_e;
   logic        stall_req;
   word_t       br_pc_e;
   logic        br_taken_e;
   word_t       rd_data_w;
   logic        rd_wen_w;
   reg_addr_t   rd_addr_w;

   string       test_name;

   exu_ecl u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task abort_with_failure;
      begin
         $display("Simulation finished: FAIL");
         $fatal(1, "run aborted");
      end
   endtask

   task check_word(input string what, input word_t exp_val, input word_t act_val);
      begin
         if (act_val !== exp_val) begin
            $display("error %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
            abort_with_failure();
         end
      end
   endtask

   task check_addr(input string what, input reg_addr_t exp_val, input reg_addr_t act_val);
      begin
         if (act_val !== exp_val) begin
            $display("error %s: %s expected %0d actual %0d", test_name, what, exp_val,
                     act_val);
            abort_with_failure();
         end
      end
   endtask

   task check_bit(input string what, input logic exp_val, input logic act_val);
      begin
         if (act_val !== exp_val) begin
            $display("error %s: %s expected %b actual %b", test_name, what, exp_val, act_val);
            abort_with_failure();
         end
      end
   endtask

   function automatic word_t rand_word();
      return {$urandom, $urandom};
   endfunction

   // register fields at their positions, the rest of the word is noise
   function automatic logic [31:0] encode_inst(input reg_addr_t rd, input reg_addr_t rj,
                                               input reg_addr_t rk);
      logic [31:0] inst;
      inst = $urandom;
      inst[`EXU_RD_LSB +: `EXU_REG_AW] = rd;
      inst[`EXU_RJ_LSB +: `EXU_REG_AW] = rj;
      inst[`EXU_RK_LSB +: `EXU_REG_AW] = rk;
      return inst;
   endfunction

   task step;
      begin
         @(negedge clk);
      end
   endtask

   task clear_inputs;
      begin
         valid_d           = 1'b0;
         inst_d            = '0;
         pc_d              = '0;
         op_d              = '0;
         rf_wen_d          = 1'b0;
         rf_target_d       = '0;
         imm_d             = '0;
         c_d               = '0;
         br_offs_d         = '0;
         rs1_data_d        = '0;
         rs2_data_d        = '0;
         alu_res_e         = '0;
         lsu_rdata_m       = '0;
         lsu_rdata_valid_m = 1'b0;
         lsu_rd_m          = '0;
         lsu_wen_m         = 1'b0;
         bru_brpc_e        = '0;
         bru_taken_e       = 1'b0;
         bru_link_pc_e     = '0;
         bru_wen_e         = 1'b0;
      end
   endtask

   // random payload for one decoded instruction
   task set_decode(input unit_e unit, input reg_addr_t rd, input reg_addr_t rj,
                   input reg_addr_t rk);
      decoded_op_t op;
      int unsigned draw;
      begin
         draw          = $urandom;
         op            = '0;
         op.unit       = unit;
         op.alu_op     = draw[`EXU_ALU_OP_W-1:0];
         op.lsu_op     = draw[8 +: `EXU_LSU_OP_W];
         op.bru_op     = draw[16 +: `EXU_BRU_OP_W];
         op.double_word = draw[31];
         op_d          = op;
         inst_d        = encode_inst(rd, rj, rk);
         valid_d       = 1'b1;
         rf_wen_d      = 1'b1;
         rf_target_d   = rd;
         pc_d          = rand_word();
         imm_d         = rand_word();
         c_d           = rand_word();
         br_offs_d     = rand_word();
         rs1_data_d    = rand_word();
         rs2_data_d    = rand_word();
      end
   endtask

   task drive_alu(input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk,
                  input logic rd2rj, input logic rd_read, input logic pc_rel,
                  input logic use_imm);
      begin
         set_decode(UNIT_ALU, rd, rj, rk);
         op_d.rd2rj      = rd2rj;
         op_d.rd_read    = rd_read;
         op_d.pc_related = pc_rel;
         op_d.use_imm    = use_imm;
      end
   endtask

   task drive_lsu(input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk,
                  input logic double_read);
      begin
         set_decode(UNIT_LSU, rd, rj, rk);
         op_d.double_read = double_read;
      end
   endtask

   task drive_bru(input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk);
      begin
         set_decode(UNIT_BRU, rd, rj, rk);
      end
   endtask

   task go_idle;
      begin
         valid_d  = 1'b0;
         rf_wen_d = 1'b0;
      end
   endtask

   // let everything in flight leave the pipeline
   task drain;
      begin
         go_idle();
         repeat (3) step();
      end
   endtask

   task apply_reset;
      begin
         rst_n = 1'b0;
         repeat (2) @(posedge clk);
         @(negedge clk);
         rst_n = 1'b1;
      end
   endtask

   `include "exu_ecl_tests.svh"

   initial begin
      #(num_tests * cycles_per_test * clk_period);
      $display("timeout: tests still running after %0d cycles", num_tests * cycles_per_test);
      abort_with_failure();
   end

   initial begin
      int unsigned first_draw;
      first_draw = $urandom(32'h51d0);
      test_name  = "setup";
      clear_inputs();
      apply_reset();
      reset_values();
      alu_operand_select();
      forwarding_paths();
      load_stall_path();
      branch_kill();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- exu_ecl.f
+incdir+verilog
+incdir+dv
verilog/exu_ecl_pkg.sv
verilog/exu_ecl_bypass.sv
verilog/exu_ecl_dispatch.sv
verilog/exu_ecl_writeback.sv
verilog/exu_ecl_lsu_stall.sv
verilog/exu_ecl.sv
dv/exu_ecl_tb.sv

//--- verilog/exu_ecl.sv
`default_nettype none

module exu_ecl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_d,
   input  logic [31:0]              inst_d,
   input  exu_ecl_pkg::word_t       pc_d,
   input  exu_ecl_pkg::decoded_op_t op_d,
   input  logic                     rf_wen_d,
   input  exu_ecl_pkg::reg_addr_t   rf_target_d,
   input  exu_ecl_pkg::word_t       imm_d,
   input  exu_ecl_pkg::word_t       c_d,
   input  exu_ecl_pkg::word_t       br_offs_d,
   input  exu_ecl_pkg::word_t       rs1_data_d,
   input  exu_ecl_pkg::word_t       rs2_data_d,
   input  exu_ecl_pkg::word_t       alu_res_e,
   input  exu_ecl_pkg::word_t       lsu_rdata_m,
   input  logic                     lsu_rdata_valid_m,
   input  exu_ecl_pkg::reg_addr_t   lsu_rd_m,
   input  logic                     lsu_wen_m,
   input  exu_ecl_pkg::word_t       bru_brpc_e,
   input  logic                     bru_taken_e,
   input  exu_ecl_pkg::word_t       bru_link_pc_e,
   input  logic                     bru_wen_e,
   output exu_ecl_pkg::reg_addr_t   rs1_addr_d,
   output exu_ecl_pkg::reg_addr_t   rs2_addr_d,
   output exu_ecl_pkg::word_t       alu_a_e,
   output exu_ecl_pkg::word_t       alu_b_e,
   output exu_ecl_pkg::alu_op_t     alu_op_e,
   output exu_ecl_pkg::word_t       alu_c_e,
   output logic                     alu_double_word_e,
   output logic                     lsu_valid_e,
   output exu_ecl_pkg::lsu_op_t     lsu_op_e,
   output exu_ecl_pkg::word_t       lsu_base_e,
   output exu_ecl_pkg::word_t       lsu_offset_e,
   output exu_ecl_pkg::word_t       lsu_wdata_e,
   output exu_ecl_pkg::reg_addr_t   lsu_rd_e,
   output logic                     lsu_wen_e,
   output logic                     bru_valid_e,
   output exu_ecl_pkg::bru_op_t     bru_op_e,
   output exu_ecl_pkg::word_t       bru_a_e,
   output exu_ecl_pkg::word_t       bru_b_e,
   output exu_ecl_pkg::word_t       bru_pc_e,
   output exu_ecl_pkg::word_t       bru_offset_e,
   output logic                     stall_req,
   output exu_ecl_pkg::word_t       br_pc_e,
   output logic                     br_taken_e,
   output exu_ecl_pkg::word_t       rd_data_w,
   output logic                     rd_wen_w,
   output exu_ecl_pkg::reg_addr_t   rd_addr_w
);
   import exu_ecl_pkg::*;

   word_t     opa_e;
   word_t     opb_e;
   word_t     imm_e;
   word_t     byp_rs1_e;
   word_t     byp_rs2_e;
   word_t     rd_data_m;
   reg_addr_t rs1_e;
   reg_addr_t rs2_e;
   reg_addr_t rd_e;
   reg_addr_t rd_m;
   logic      use_other_rs1_e;
   logic      use_other_rs2_e;
   logic      double_read_e;
   logic      alu_wen_e;
   logic      wen_m;
   logic      lsu_dispatch_d;

   exu_ecl_dispatch u_dispatch (
      .clk               (clk),
      .rst_n             (rst_n),
      .valid_d           (valid_d),
      .inst_d            (inst_d),
      .pc_d              (pc_d),
      .op_d              (op_d),
      .rf_wen_d          (rf_wen_d),
      .rf_target_d       (rf_target_d),
      .imm_d             (imm_d),
      .c_d               (c_d),
      .br_offs_d         (br_offs_d),
      .rs1_data_d        (rs1_data_d),
      .rs2_data_d        (rs2_data_d),
      .bru_taken_e       (bru_taken_e),
      .rs1_addr_d        (rs1_addr_d),
      .rs2_addr_d        (rs2_addr_d),
      .opa_e             (opa_e),
      .opb_e             (opb_e),
      .rs1_e             (rs1_e),
      .rs2_e             (rs2_e),
      .use_other_rs1_e   (use_other_rs1_e),
      .use_other_rs2_e   (use_other_rs2_e),
      .imm_e             (imm_e),
      .double_read_e     (double_read_e),
      .alu_op_e          (alu_op_e),
      .alu_c_e           (alu_c_e),
      .alu_double_word_e (alu_double_word_e),
      .lsu_valid_e       (lsu_valid_e),
      .lsu_op_e          (lsu_op_e),
      .lsu_rd_e          (lsu_rd_e),
      .lsu_wen_e         (lsu_wen_e),
      .bru_valid_e       (bru_valid_e),
      .bru_op_e          (bru_op_e),
      .bru_pc_e          (bru_pc_e),
      .bru_offset_e      (bru_offset_e),
      .rd_e              (rd_e),
      .alu_wen_e         (alu_wen_e),
      .lsu_dispatch_d    (lsu_dispatch_d),
      .br_taken_e        (br_taken_e)
   );

   exu_ecl_bypass u_byp_rs1 (
      .rs_e      (rs1_e),
      .use_other (use_other_rs1_e),
      .reg_val   (opa_e),
      .rd_m      (rd_m),
      .wen_m     (wen_m),
      .data_m    (rd_data_m),
      .rd_w      (rd_addr_w),
      .wen_w     (rd_wen_w),
      .data_w    (rd_data_w),
      .val_e     (byp_rs1_e)
   );

   exu_ecl_bypass u_byp_rs2 (
      .rs_e      (rs2_e),
      .use_other (use_other_rs2_e),
      .reg_val   (opb_e),
      .rd_m      (rd_m),
      .wen_m     (wen_m),
      .data_m    (rd_data_m),
      .rd_w      (rd_addr_w),
      .wen_w     (rd_wen_w),
      .data_w    (rd_data_w),
      .val_e     (byp_rs2_e)
   );

   // forwarded sources feed every unit
   assign alu_a_e     = byp_rs1_e;
   assign alu_b_e     = byp_rs2_e;
   assign lsu_base_e  = byp_rs1_e;
   assign lsu_wdata_e = byp_rs2_e;
   assign bru_a_e     = byp_rs1_e;
   assign bru_b_e     = byp_rs2_e;

   // register offset for indexed accesses, immediate otherwise
   assign lsu_offset_e = double_read_e ? byp_rs2_e : imm_e;

   assign br_pc_e = bru_brpc_e;

   exu_ecl_writeback u_writeback (
      .clk               (clk),
      .rst_n             (rst_n),
      .rd_e              (rd_e),
      .alu_wen_e         (alu_wen_e),
      .alu_res_e         (alu_res_e),
      .lsu_rdata_m       (lsu_rdata_m),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .lsu_rd_m          (lsu_rd_m),
      .lsu_wen_m         (lsu_wen_m),
      .bru_link_pc_e     (bru_link_pc_e),
      .bru_wen_e         (bru_wen_e),
      .rd_m              (rd_m),
      .wen_m             (wen_m),
      .rd_data_m         (rd_data_m),
      .rd_w              (rd_addr_w),
      .wen_w             (rd_wen_w),
      .rd_data_w         (rd_data_w)
   );

   exu_ecl_lsu_stall u_lsu_stall (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_dispatch_d    (lsu_dispatch_d),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .stall_req         (stall_req)
   );

endmodule

`default_nettype wire

//--- verilog/exu_ecl_bypass.sv
`default_nettype none

module exu_ecl_bypass (
   input  exu_ecl_pkg::reg_addr_t rs_e,
   input  logic                   use_other,
   input  exu_ecl_pkg::word_t     reg_val,
   input  exu_ecl_pkg::reg_addr_t rd_m,
   input  logic                   wen_m,
   input  exu_ecl_pkg::word_t     data_m,
   input  exu_ecl_pkg::reg_addr_t rd_w,
   input  logic                   wen_w,
   input  exu_ecl_pkg::word_t     data_w,
   output exu_ecl_pkg::word_t     val_e
);

   logic rs_nonzero;
   logic hit_m;
   logic hit_w;

   // r0 reads as zero, never forward into it
   assign rs_nonzero = |rs_e;

   assign hit_m = wen_m & (rd_m == rs_e) & rs_nonzero & ~use_other;
   assign hit_w = wen_w & (rd_w == rs_e) & rs_nonzero & ~use_other;

   // younger memory stage result wins over writeback
   always_comb begin
      if (hit_m) begin
         val_e = data_m;
      end else if (hit_w) begin
         val_e = data_w;
      end else begin
         val_e = reg_val;
      end
   end

endmodule

`default_nettype wire

//--- verilog/exu_ecl_config.svh
`ifndef EXU_ECL_CONFIG_SVH
`define EXU_ECL_CONFIG_SVH

// general register width
`define EXU_GRLEN 64

// register index width, 32 architectural registers
`define EXU_REG_AW 5

// low bit of each register field in the instruction word
`define EXU_RD_LSB 0
`define EXU_RJ_LSB 5
`define EXU_RK_LSB 10

// opcode widths handed to each unit
`define EXU_ALU_OP_W 6
`define EXU_LSU_OP_W 8
`define EXU_BRU_OP_W 4

`endif

//--- verilog/exu_ecl_dispatch.sv
`default_nettype none

`include "exu_ecl_config.svh"

module exu_ecl_dispatch (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_d,
   input  logic [31:0]              inst_d,
   input  exu_ecl_pkg::word_t       pc_d,
   input  exu_ecl_pkg::decoded_op_t op_d,
   input  logic                     rf_wen_d,
   input  exu_ecl_pkg::reg_addr_t   rf_target_d,
   input  exu_ecl_pkg::word_t       imm_d,
   input  exu_ecl_pkg::word_t       c_d,
   input  exu_ecl_pkg::word_t       br_offs_d,
   input  exu_ecl_pkg::word_t       rs1_data_d,
   input  exu_ecl_pkg::word_t       rs2_data_d,
   input  logic                     bru_taken_e,
   output exu_ecl_pkg::reg_addr_t   rs1_addr_d,
   output exu_ecl_pkg::reg_addr_t   rs2_addr_d,
   output exu_ecl_pkg::word_t       opa_e,
   output exu_ecl_pkg::word_t       opb_e,
   output exu_ecl_pkg::reg_addr_t   rs1_e,
   output exu_ecl_pkg::reg_addr_t   rs2_e,
   output logic                     use_other_rs1_e,
   output logic                     use_other_rs2_e,
   output exu_ecl_pkg::word_t       imm_e,
   output logic                     double_read_e,
   output exu_ecl_pkg::alu_op_t     alu_op_e,
   output exu_ecl_pkg::word_t       alu_c_e,
   output logic                     alu_double_word_e,
   output logic                     lsu_valid_e,
   output exu_ecl_pkg::lsu_op_t     lsu_op_e,
   output exu_ecl_pkg::reg_addr_t   lsu_rd_e,
   output logic                     lsu_wen_e,
   output logic                     bru_valid_e,
   output exu_ecl_pkg::bru_op_t     bru_op_e,
   output exu_ecl_pkg::word_t       bru_pc_e,
   output exu_ecl_pkg::word_t       bru_offset_e,
   output exu_ecl_pkg::reg_addr_t   rd_e,
   output logic                     alu_wen_e,
   output logic                     lsu_dispatch_d,
   output logic                     br_taken_e
);
   import exu_ecl_pkg::*;

   logic  kill_d;
   logic  inst_vld_d;
   logic  is_alu_d;
   logic  alu_dispatch_d;
   logic  bru_dispatch_d;
   logic  a_pc_d;
   logic  b_imm_d;
   logic  double_read_d;
   word_t opa_d;
   word_t opb_d;

   // a taken branch in execute squashes whatever sits in decode
   assign kill_d     = bru_valid_e & bru_taken_e;
   assign br_taken_e = kill_d;
   assign inst_vld_d = valid_d & ~kill_d;

   assign is_alu_d       = (op_d.unit == UNIT_ALU);
   assign alu_dispatch_d = inst_vld_d & is_alu_d;
   assign lsu_dispatch_d = inst_vld_d & (op_d.unit == UNIT_LSU);
   assign bru_dispatch_d = inst_vld_d & (op_d.unit == UNIT_BRU);

   // register file read ports
   assign rs1_addr_d = op_d.rd2rj ? inst_d[`EXU_RD_LSB +: `EXU_REG_AW]
                                  : inst_d[`EXU_RJ_LSB +: `EXU_REG_AW];
   assign rs2_addr_d = op_d.rd_read ? inst_d[`EXU_RD_LSB +: `EXU_REG_AW]
                                    : inst_d[`EXU_RK_LSB +: `EXU_REG_AW];

   // pc and immediate only replace register operands for alu ops
   assign a_pc_d        = op_d.pc_related & is_alu_d;
   assign b_imm_d       = op_d.use_imm & is_alu_d;
   assign double_read_d = op_d.double_read & lsu_dispatch_d;

   assign opa_d = a_pc_d ? pc_d : rs1_data_d;
   assign opb_d = b_imm_d ? imm_d : rs2_data_d;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_e   <= 1'b0;
         lsu_valid_e <= 1'b0;
         lsu_wen_e   <= 1'b0;
         bru_valid_e <= 1'b0;
      end else begin
         alu_wen_e   <= alu_dispatch_d & rf_wen_d;
         lsu_valid_e <= lsu_dispatch_d;
         lsu_wen_e   <= lsu_dispatch_d & rf_wen_d;
         bru_valid_e <= bru_dispatch_d;
      end
   end

   // decode to execute payload
   always_ff @(posedge clk) begin
      opa_e             <= opa_d;
      opb_e             <= opb_d;
      rs1_e             <= rs1_addr_d;
      rs2_e             <= rs2_addr_d;
      use_other_rs1_e   <= a_pc_d;
      use_other_rs2_e   <= b_imm_d | double_read_d;
      imm_e             <= imm_d;
      double_read_e     <= double_read_d;
      alu_op_e          <= op_d.alu_op;
      alu_c_e           <= c_d;
      alu_double_word_e <= op_d.double_word;
      lsu_op_e          <= op_d.lsu_op;
      lsu_rd_e          <= rf_target_d;
      bru_op_e          <= op_d.bru_op;
      bru_pc_e          <= pc_d;
      bru_offset_e      <= br_offs_d;
      rd_e              <= rf_target_d;
   end

endmodule

`default_nettype wire

//--- verilog/exu_ecl_lsu_stall.sv
`default_nettype none

module exu_ecl_lsu_stall (
   input  logic clk,
   input  logic rst_n,
   input  logic lsu_dispatch_d,
   input  logic lsu_rdata_valid_m,
   output logic stall_req
);

   typedef enum logic {
      IDLE      = 1'b0,
      WAIT_DATA = 1'b1
   } state_e;

   state_e state_q;
   state_e state_d;

   // a new dispatch always (re)arms the wait
   always_comb begin
      state_d = state_q;
      if (lsu_dispatch_d) begin
         state_d = WAIT_DATA;
      end else if (state_q == WAIT_DATA && lsu_rdata_valid_m) begin
         state_d = IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // raised in the dispatch cycle already, dropped when data shows up
   assign stall_req = lsu_dispatch_d | ((state_q == WAIT_DATA) & ~lsu_rdata_valid_m);

   // load data only returns for an outstanding dispatch
   a_no_stray_data: assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_rdata_valid_m && state_q == IDLE) |-> $past(lsu_dispatch_d));

endmodule

`default_nettype wire

//--- verilog/exu_ecl_pkg.sv
`default_nettype none

`include "exu_ecl_config.svh"

package exu_ecl_pkg;

   typedef logic [`EXU_GRLEN-1:0]  word_t;
   typedef logic [`EXU_REG_AW-1:0] reg_addr_t;

   // unit that executes the instruction
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_LSU = 2'd1,
      UNIT_BRU = 2'd2
   } unit_e;

   typedef logic [`EXU_ALU_OP_W-1:0] alu_op_t;
   typedef logic [`EXU_LSU_OP_W-1:0] lsu_op_t;
   typedef logic [`EXU_BRU_OP_W-1:0] bru_op_t;

   // decoded instruction as delivered by fetch
   typedef struct packed {
      unit_e   unit;
      alu_op_t alu_op;
      lsu_op_t lsu_op;
      bru_op_t bru_op;
      // first source reads rd instead of rj
      logic    rd2rj;
      // second source reads rd instead of rk
      logic    rd_read;
      // operand a is the pc
      logic    pc_related;
      // operand b is the immediate
      logic    use_imm;
      logic    double_word;
      // load/store offset comes from rs2
      logic    double_read;
   } decoded_op_t;

endpackage

`default_nettype wire

//--- verilog/exu_ecl_writeback.sv
`default_nettype none

module exu_ecl_writeback (
   input  logic                   clk,
   input  logic                   rst_n,
   input  exu_ecl_pkg::reg_addr_t rd_e,
   input  logic                   alu_wen_e,
   input  exu_ecl_pkg::word_t     alu_res_e,
   input  exu_ecl_pkg::word_t     lsu_rdata_m,
   input  logic                   lsu_rdata_valid_m,
   input  exu_ecl_pkg::reg_addr_t lsu_rd_m,
   input  logic                   lsu_wen_m,
   input  exu_ecl_pkg::word_t     bru_link_pc_e,
   input  logic                   bru_wen_e,
   output exu_ecl_pkg::reg_addr_t rd_m,
   output logic                   wen_m,
   output exu_ecl_pkg::word_t     rd_data_m,
   output exu_ecl_pkg::reg_addr_t rd_w,
   output logic                   wen_w,
   output exu_ecl_pkg::word_t     rd_data_w
);
   import exu_ecl_pkg::*;

   reg_addr_t rf_target_m;
   word_t     alu_res_m;
   word_t     bru_link_pc_m;
   logic      alu_wen_m;
   logic      bru_wen_m;

   // execute to memory
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_m <= 1'b0;
         bru_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen_e;
         bru_wen_m <= bru_wen_e;
      end
   end

   always_ff @(posedge clk) begin
      rf_target_m   <= rd_e;
      alu_res_m     <= alu_res_e;
      bru_link_pc_m <= bru_link_pc_e;
   end

   // returning load data brings its own destination
   assign rd_m = lsu_rdata_valid_m ? lsu_rd_m : rf_target_m;

   // any unit may claim the write port
   assign wen_m = alu_wen_m | (lsu_wen_m & lsu_rdata_valid_m) | bru_wen_m;

   always_comb begin
      if (bru_wen_m) begin
         rd_data_m = bru_link_pc_m;
      end else if (lsu_rdata_valid_m) begin
         rd_data_m = lsu_rdata_m;
      end else begin
         // alu result is the default source
         rd_data_m = alu_res_m;
      end
   end

   // memory to writeback
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      rd_w      <= rd_m;
      rd_data_w <= rd_data_m;
   end

   // link write and load return cannot share the memory stage
   a_wb_conflict: assert property (@(posedge clk) disable iff (!rst_n)
      !(bru_wen_m && lsu_rdata_valid_m));

endmodule

`default_nettype wire
